//--- hdl/rv_pkg.sv
/*
 * Shared definitions for the RV32I pipeline core
 * Data width, reset PC and the NOP word
 * Opcode, ALU operation and forwarding select enums
 */
package rv_pkg;

	// ==============================
	// Widths and constants
	// ==============================

	// Data and address width
	localparam int XLEN = 32;

	// First fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// ADDI x0, x0, 0 used as bubble
	localparam logic [31:0] NOP_INST = 32'h0000_0013;

	// ==============================
	// Enums
	// ==============================

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_t;

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_t;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

endpackage

//--- hdl/rv_decoder.sv
/*
 * RV32I subset decoder
 * Register indices, immediate formats and control levels
 */
`timescale 1ns/10ps

module rv_decoder
(
	input  logic [31:0]              i_inst,
	output logic [4:0]               o_rs1,
	output logic [4:0]               o_rs2,
	output logic [4:0]               o_rd,
	output logic [rv_pkg::XLEN-1:0]  o_imm,
	output rv_pkg::alu_op_t          o_alu_op,
	output logic                     o_use_imm,
	output logic                     o_use_pc,
	output logic                     o_reg_we,
	output logic                     o_mem_re,
	output logic                     o_mem_we,
	output logic                     o_branch,
	output logic                     o_jal,
	output logic                     o_jalr,
	output logic [2:0]               o_br_func
);
	import rv_pkg::*;

	opcode_t         opcode;
	logic [2:0]      funct3;
	logic            funct7_b5;
	logic            is_nop;
	alu_op_t         arith_op;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;

	// Fixed field positions
	assign opcode    = opcode_t'(i_inst[6:0]);
	assign funct3    = i_inst[14:12];
	assign funct7_b5 = i_inst[30];
	assign o_rs1     = i_inst[19:15];
	assign o_rs2     = i_inst[24:20];
	assign o_rd      = i_inst[11:7];
	assign o_br_func = funct3;
	// Flushed slot, keep every enable low
	assign is_nop    = (i_inst == NOP_INST);

	// ==============================
	// Immediate formats
	// ==============================
	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
		i_inst[30:21], 1'b0};

	// Register and immediate arithmetic share funct3
	always_comb
	begin
		case (funct3)
			// SUB only for register form with funct7 bit 5
			3'b000:  arith_op = (opcode == OP && funct7_b5) ? ALU_SUB : ALU_ADD;
			3'b010:  arith_op = ALU_SLT;
			3'b100:  arith_op = ALU_XOR;
			3'b110:  arith_op = ALU_OR;
			3'b111:  arith_op = ALU_AND;
			default: arith_op = ALU_ADD;
		endcase
	end

	// ==============================
	// Control decode
	// ==============================
	always_comb
	begin
		o_imm     = imm_i;
		o_alu_op  = ALU_PASS_B;
		o_use_imm = 1'b0;
		o_use_pc  = 1'b0;
		o_reg_we  = 1'b0;
		o_mem_re  = 1'b0;
		o_mem_we  = 1'b0;
		o_branch  = 1'b0;
		o_jal     = 1'b0;
		o_jalr    = 1'b0;
		case (opcode)
			OP:
			begin
				o_alu_op = arith_op;
				o_reg_we = 1'b1;
			end
			OP_IMM:
			begin
				o_alu_op  = arith_op;
				o_use_imm = 1'b1;
				o_reg_we  = 1'b1;
			end
			LOAD:
			begin
				// Address is rs1 + imm
				o_alu_op  = ALU_ADD;
				o_use_imm = 1'b1;
				o_reg_we  = 1'b1;
				o_mem_re  = 1'b1;
			end
			STORE:
			begin
				o_imm     = imm_s;
				o_alu_op  = ALU_ADD;
				o_use_imm = 1'b1;
				o_mem_we  = 1'b1;
			end
			BRANCH:
			begin
				o_imm    = imm_b;
				o_alu_op = ALU_SUB;
				o_branch = 1'b1;
			end
			JAL:
			begin
				// ALU sums PC + imm, result replaced by link in execute
				o_imm     = imm_j;
				o_alu_op  = ALU_ADD;
				o_use_imm = 1'b1;
				o_use_pc  = 1'b1;
				o_reg_we  = 1'b1;
				o_jal     = 1'b1;
			end
			JALR:
			begin
				o_alu_op  = ALU_ADD;
				o_use_imm = 1'b1;
				o_reg_we  = 1'b1;
				o_jalr    = 1'b1;
			end
			default:
			begin
				// Unknown opcode, nothing enabled
				o_alu_op = ALU_PASS_B;
			end
		endcase
		if (is_nop)
		begin
			o_reg_we = 1'b0;
		end
	end

endmodule

//--- hdl/rv_regfile.sv
/*
 * 32 x XLEN register file
 * Two combinational reads, one write, x0 tied to zero, write bypass
 */
`timescale 1ns/10ps

module rv_regfile
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [4:0]              i_rs1,
	input  logic [4:0]              i_rs2,
	input  logic [4:0]              i_rd,
	input  logic                    i_we,
	input  logic [rv_pkg::XLEN-1:0] i_wdata,
	output logic [rv_pkg::XLEN-1:0] o_rs1_data,
	output logic [rv_pkg::XLEN-1:0] o_rs2_data
);
	// x1..x31 only, x0 has no storage
	logic [rv_pkg::XLEN-1:0] regs [1:31];
	logic                    wr_valid;

	assign wr_valid = i_we && (i_rd != 5'd0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_valid)
		begin
			regs[i_rd] <= i_wdata;
		end
	end

	// Same-cycle writeback seen by decode
	assign o_rs1_data = (i_rs1 == 5'd0) ? '0 :
		(wr_valid && i_rd == i_rs1) ? i_wdata : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? '0 :
		(wr_valid && i_rd == i_rs2) ? i_wdata : regs[i_rs2];

endmodule

//--- hdl/rv_alu_exec.sv
/*
 * Execute stage datapath
 * ALU, link value, branch compare and redirect target
 */
`timescale 1ns/10ps

module rv_alu_exec
(
	input  rv_pkg::alu_op_t         i_alu_op,
	input  logic [rv_pkg::XLEN-1:0] i_op_a,
	input  logic [rv_pkg::XLEN-1:0] i_op_b,
	input  logic [rv_pkg::XLEN-1:0] i_rs1_val,
	input  logic [rv_pkg::XLEN-1:0] i_rs2_val,
	input  logic [rv_pkg::XLEN-1:0] i_pc,
	input  logic [rv_pkg::XLEN-1:0] i_imm,
	input  logic                    i_branch,
	input  logic                    i_jal,
	input  logic                    i_jalr,
	input  logic [2:0]              i_br_func,
	output logic [rv_pkg::XLEN-1:0] o_result,
	output logic [rv_pkg::XLEN-1:0] o_target,
	output logic                    o_taken
);
	import rv_pkg::*;

	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] link;
	logic [XLEN-1:0] jalr_sum;
	logic            br_cond;

	// ==============================
	// ALU
	// ==============================
	always_comb
	begin
		case (i_alu_op)
			ALU_ADD:  alu_out = i_op_a + i_op_b;
			ALU_SUB:  alu_out = i_op_a - i_op_b;
			ALU_AND:  alu_out = i_op_a & i_op_b;
			ALU_OR:   alu_out = i_op_a | i_op_b;
			ALU_XOR:  alu_out = i_op_a ^ i_op_b;
			ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(i_op_a) < $signed(i_op_b)};
			default:  alu_out = i_op_b;
		endcase
	end

	// Jumps write back the return address
	assign link     = i_pc + XLEN'(4);
	assign o_result = (i_jal || i_jalr) ? link : alu_out;

	// ==============================
	// Branch resolution
	// ==============================
	// Compare on forwarded register values
	always_comb
	begin
		case (i_br_func)
			3'b000:  br_cond = (i_rs1_val == i_rs2_val);
			3'b001:  br_cond = (i_rs1_val != i_rs2_val);
			3'b100:  br_cond = ($signed(i_rs1_val) < $signed(i_rs2_val));
			3'b101:  br_cond = ($signed(i_rs1_val) >= $signed(i_rs2_val));
			default: br_cond = 1'b0;
		endcase
	end

	assign o_taken = i_jal || i_jalr || (i_branch && br_cond);

	// JALR target with bit 0 cleared
	assign jalr_sum = i_rs1_val + i_imm;
	assign o_target = i_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : (i_pc + i_imm);

endmodule

//--- hdl/rv_forward_unit.sv
/*
 * Operand forwarding selects and load-use stall detection
 */
`timescale 1ns/10ps

module rv_forward_unit
(
	input  logic [4:0]       i_ex_rs1,
	input  logic [4:0]       i_ex_rs2,
	input  logic [4:0]       i_id_rs1,
	input  logic [4:0]       i_id_rs2,
	input  logic [4:0]       i_mem_rd,
	input  logic [4:0]       i_wb_rd,
	input  logic [4:0]       i_ex_rd,
	input  logic             i_mem_we,
	input  logic             i_wb_we,
	input  logic             i_ex_load,
	output rv_pkg::fwd_sel_t o_fwd_a,
	output rv_pkg::fwd_sel_t o_fwd_b,
	output logic             o_load_stall
);
	import rv_pkg::*;

	// Youngest producer wins and x0 is never forwarded
	function automatic fwd_sel_t pick_src(input logic [4:0] rs);
		fwd_sel_t sel;
		sel = FWD_REG;
		if (rs != 5'd0)
		begin
			if (i_mem_we && i_mem_rd == rs)
			begin
				sel = FWD_MEM;
			end
			else if (i_wb_we && i_wb_rd == rs)
			begin
				sel = FWD_WB;
			end
		end
		return sel;
	endfunction

	always_comb
	begin
		o_fwd_a = pick_src(i_ex_rs1);
		o_fwd_b = pick_src(i_ex_rs2);
	end

	// Load data not ready until end of memory stage
	assign o_load_stall = i_ex_load && (i_ex_rd != 5'd0) &&
		((i_ex_rd == i_id_rs1) || (i_ex_rd == i_id_rs2));

endmodule

//--- hdl/rv_core.sv
/*
 * Five-stage in-order RV32I core
 * PC, pipeline registers, halt / flush / stall control
 * Operand forwarding muxes and external memory ports
 */
`timescale 1ns/10ps

module rv_core
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_halt,
	output logic [rv_pkg::XLEN-1:0] o_imem_addr,
	input  logic [31:0]             i_imem_data,
	output logic [rv_pkg::XLEN-1:0] o_dmem_addr,
	output logic [rv_pkg::XLEN-1:0] o_dmem_wdata,
	output logic                    o_dmem_we,
	output logic                    o_dmem_re,
	input  logic [rv_pkg::XLEN-1:0] i_dmem_rdata
);
	import rv_pkg::*;

	logic [XLEN-1:0] pc;
	// Fetch / decode
	logic [XLEN-1:0] if_id_pc;
	logic [31:0]     if_id_inst;
	// Decoder and register file outputs
	logic [4:0]      dec_rs1;
	logic [4:0]      dec_rs2;
	logic [4:0]      dec_rd;
	logic [XLEN-1:0] dec_imm;
	alu_op_t         dec_alu_op;
	logic            dec_use_imm;
	logic            dec_use_pc;
	logic            dec_reg_we;
	logic            dec_mem_re;
	logic            dec_mem_we;
	logic            dec_branch;
	logic            dec_jal;
	logic            dec_jalr;
	logic [2:0]      dec_br_func;
	logic [XLEN-1:0] rf_rs1_data;
	logic [XLEN-1:0] rf_rs2_data;
	// Decode / execute
	logic [XLEN-1:0] id_ex_pc;
	logic [4:0]      id_ex_rs1;
	logic [4:0]      id_ex_rs2;
	logic [4:0]      id_ex_rd;
	logic [XLEN-1:0] id_ex_imm;
	logic [XLEN-1:0] id_ex_rs1_data;
	logic [XLEN-1:0] id_ex_rs2_data;
	alu_op_t         id_ex_alu_op;
	logic            id_ex_use_imm;
	logic            id_ex_use_pc;
	logic            id_ex_reg_we;
	logic            id_ex_mem_re;
	logic            id_ex_mem_we;
	logic            id_ex_branch;
	logic            id_ex_jal;
	logic            id_ex_jalr;
	logic [2:0]      id_ex_br_func;
	// Execute
	fwd_sel_t        fwd_a;
	fwd_sel_t        fwd_b;
	logic            load_stall;
	logic            id_ex_kill;
	logic [XLEN-1:0] rs1_fwd;
	logic [XLEN-1:0] rs2_fwd;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] ex_result;
	logic [XLEN-1:0] ex_target;
	logic            ex_taken;
	// Execute / memory
	logic [4:0]      ex_mem_rd;
	logic            ex_mem_reg_we;
	logic            ex_mem_mem_re;
	logic            ex_mem_mem_we;
	logic [XLEN-1:0] ex_mem_alu;
	logic [XLEN-1:0] ex_mem_store_data;
	// Memory / writeback
	logic [4:0]      mem_wb_rd;
	logic            mem_wb_reg_we;
	logic            mem_wb_mem_re;
	logic [XLEN-1:0] mem_wb_load_data;
	logic [XLEN-1:0] mem_wb_alu;
	logic [XLEN-1:0] wb_data;

	// Forwarded value for one operand
	function automatic logic [XLEN-1:0] fwd_value(input fwd_sel_t sel,
		input logic [XLEN-1:0] reg_val, input logic [XLEN-1:0] mem_val,
		input logic [XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// ==============================
	// Fetch
	// ==============================
	// Halt over redirect over stall
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc         <= RESET_PC;
			if_id_pc   <= RESET_PC;
			if_id_inst <= NOP_INST;
		end
		else if (!i_halt)
		begin
			if (ex_taken)
			begin
				pc         <= ex_target;
				if_id_inst <= NOP_INST;
			end
			else if (!load_stall)
			begin
				pc         <= pc + XLEN'(4);
				if_id_pc   <= pc;
				if_id_inst <= i_imem_data;
			end
		end
	end

	assign o_imem_addr = pc;

	// ==============================
	// Decode
	// ==============================
	rv_decoder u_decoder
	(
		.i_inst    (if_id_inst),
		.o_rs1     (dec_rs1),
		.o_rs2     (dec_rs2),
		.o_rd      (dec_rd),
		.o_imm     (dec_imm),
		.o_alu_op  (dec_alu_op),
		.o_use_imm (dec_use_imm),
		.o_use_pc  (dec_use_pc),
		.o_reg_we  (dec_reg_we),
		.o_mem_re  (dec_mem_re),
		.o_mem_we  (dec_mem_we),
		.o_branch  (dec_branch),
		.o_jal     (dec_jal),
		.o_jalr    (dec_jalr),
		.o_br_func (dec_br_func)
	);

	// Writes masked while halted
	rv_regfile u_regfile
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.i_rs1      (dec_rs1),
		.i_rs2      (dec_rs2),
		.i_rd       (mem_wb_rd),
		.i_we       (mem_wb_reg_we && !i_halt),
		.i_wdata    (wb_data),
		.o_rs1_data (rf_rs1_data),
		.o_rs2_data (rf_rs2_data)
	);

	// Bubble on redirect or load-use
	assign id_ex_kill = ex_taken || load_stall;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			id_ex_reg_we <= 1'b0;
			id_ex_mem_re <= 1'b0;
			id_ex_mem_we <= 1'b0;
			id_ex_branch <= 1'b0;
			id_ex_jal    <= 1'b0;
			id_ex_jalr   <= 1'b0;
		end
		else if (!i_halt)
		begin
			id_ex_reg_we <= dec_reg_we && !id_ex_kill;
			id_ex_mem_re <= dec_mem_re && !id_ex_kill;
			id_ex_mem_we <= dec_mem_we && !id_ex_kill;
			id_ex_branch <= dec_branch && !id_ex_kill;
			id_ex_jal    <= dec_jal && !id_ex_kill;
			id_ex_jalr   <= dec_jalr && !id_ex_kill;
		end
	end

	// Decode / execute payload
	always_ff @(posedge clk)
	begin
		if (!i_halt)
		begin
			id_ex_pc       <= if_id_pc;
			id_ex_rs1      <= dec_rs1;
			id_ex_rs2      <= dec_rs2;
			id_ex_rd       <= dec_rd;
			id_ex_imm      <= dec_imm;
			id_ex_rs1_data <= rf_rs1_data;
			id_ex_rs2_data <= rf_rs2_data;
			id_ex_alu_op   <= dec_alu_op;
			id_ex_use_imm  <= dec_use_imm;
			id_ex_use_pc   <= dec_use_pc;
			id_ex_br_func  <= dec_br_func;
		end
	end

	// ==============================
	// Execute
	// ==============================
	rv_forward_unit u_forward_unit
	(
		.i_ex_rs1     (id_ex_rs1),
		.i_ex_rs2     (id_ex_rs2),
		.i_id_rs1     (dec_rs1),
		.i_id_rs2     (dec_rs2),
		.i_mem_rd     (ex_mem_rd),
		.i_wb_rd      (mem_wb_rd),
		.i_ex_rd      (id_ex_rd),
		.i_mem_we     (ex_mem_reg_we),
		.i_wb_we      (mem_wb_reg_we),
		.i_ex_load    (id_ex_mem_re),
		.o_fwd_a      (fwd_a),
		.o_fwd_b      (fwd_b),
		.o_load_stall (load_stall)
	);

	// rs2_fwd also carries the store data
	assign rs1_fwd = fwd_value(fwd_a, id_ex_rs1_data, ex_mem_alu, wb_data);
	assign rs2_fwd = fwd_value(fwd_b, id_ex_rs2_data, ex_mem_alu, wb_data);
	assign op_a    = id_ex_use_pc ? id_ex_pc : rs1_fwd;
	assign op_b    = id_ex_use_imm ? id_ex_imm : rs2_fwd;

	rv_alu_exec u_alu_exec
	(
		.i_alu_op  (id_ex_alu_op),
		.i_op_a    (op_a),
		.i_op_b    (op_b),
		.i_rs1_val (rs1_fwd),
		.i_rs2_val (rs2_fwd),
		.i_pc      (id_ex_pc),
		.i_imm     (id_ex_imm),
		.i_branch  (id_ex_branch),
		.i_jal     (id_ex_jal),
		.i_jalr    (id_ex_jalr),
		.i_br_func (id_ex_br_func),
		.o_result  (ex_result),
		.o_target  (ex_target),
		.o_taken   (ex_taken)
	);

	// ==============================
	// Memory and writeback
	// ==============================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_mem_reg_we <= 1'b0;
			ex_mem_mem_re <= 1'b0;
			ex_mem_mem_we <= 1'b0;
			mem_wb_reg_we <= 1'b0;
			mem_wb_mem_re <= 1'b0;
		end
		else if (!i_halt)
		begin
			ex_mem_reg_we <= id_ex_reg_we;
			ex_mem_mem_re <= id_ex_mem_re;
			ex_mem_mem_we <= id_ex_mem_we;
			mem_wb_reg_we <= ex_mem_reg_we;
			mem_wb_mem_re <= ex_mem_mem_re;
		end
	end

	// Load data sampled at end of memory stage
	always_ff @(posedge clk)
	begin
		if (!i_halt)
		begin
			ex_mem_rd         <= id_ex_rd;
			ex_mem_alu        <= ex_result;
			ex_mem_store_data <= rs2_fwd;
			mem_wb_rd         <= ex_mem_rd;
			mem_wb_alu        <= ex_mem_alu;
			mem_wb_load_data  <= i_dmem_rdata;
		end
	end

	assign o_dmem_addr  = ex_mem_alu;
	assign o_dmem_wdata = ex_mem_store_data;
	// Held store fires once after halt drops
	assign o_dmem_we    = ex_mem_mem_we && !i_halt;
	assign o_dmem_re    = ex_mem_mem_re;

	assign wb_data = mem_wb_mem_re ? mem_wb_load_data : mem_wb_alu;

endmodule

//--- tests/rv_core_assertions.sv
/*
 * Concurrent checks on rv_core control behavior
 * Bound into the core from this file
 */
`timescale 1ns/10ps

module rv_core_assertions
(
	input logic                    clk,
	input logic                    rst_n,
	input logic                    i_halt,
	input logic                    i_dmem_we,
	input logic                    i_dmem_re,
	input logic [rv_pkg::XLEN-1:0] i_pc,
	input logic                    i_ex_taken,
	input logic                    i_id_ex_busy
);
	import rv_pkg::*;

	// ==============================
	// Memory strobes
	// ==============================
	// Store never fires while frozen
	a_no_we_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
		i_halt |-> !i_dmem_we)
		else $error("dmem write strobe high during halt");

	a_we_re_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_dmem_we && i_dmem_re))
		else $error("dmem read and write both high");

	// ==============================
	// PC and flush
	// ==============================
	a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
		i_halt |=> i_pc == $past(i_pc))
		else $error("PC moved across a halt cycle");

	// Redirect leaves a bubble behind it
	a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		(i_ex_taken && !i_halt) |=> !i_id_ex_busy)
		else $error("decode/execute not cleared after taken branch");

	a_reset_pc: assert property (@(posedge clk)
		$rose(rst_n) |-> i_pc == RESET_PC)
		else $error("PC not at reset address after reset");

endmodule

bind rv_core rv_core_assertions u_assertions
(
	.clk          (clk),
	.rst_n        (rst_n),
	.i_halt       (i_halt),
	.i_dmem_we    (o_dmem_we),
	.i_dmem_re    (o_dmem_re),
	.i_pc         (pc),
	.i_ex_taken   (ex_taken),
	.i_id_ex_busy (id_ex_reg_we || id_ex_mem_re || id_ex_mem_we ||
		id_ex_branch || id_ex_jal || id_ex_jalr)
);

//--- tests/rv_core_tb.sv
/*
 * Testbench for rv_core
 * Program and expected stores from the patterns file
 * Memory models, random halts, store checks and report
 */
`timescale 1ns/10ps

module rv_core_tb;
	import rv_pkg::*;

	// ==============================
	// Signals and storage
	// ==============================
	logic              clk;
	logic              rst_n;
	logic              i_halt;
	logic [XLEN-1:0]   o_imem_addr;
	logic [31:0]       i_imem_data;
	logic [XLEN-1:0]   o_dmem_addr;
	logic [XLEN-1:0]   o_dmem_wdata;
	logic              o_dmem_we;
	logic              o_dmem_re;
	logic [XLEN-1:0]   i_dmem_rdata;

	// Raw file image with program and record tables
	logic [31:0] pat [0:511];
	logic [31:0] prog [0:255];
	logic [31:0] dmem [0:255];
	int          rec_test [0:63];
	logic [31:0] rec_addr [0:63];
	logic [31:0] rec_data [0:63];
	int          prog_len;
	int          rec_count;
	int          store_idx;
	int          test_err [1:5];
	int          check_count;
	int          err_count;
	int          halt_left;
	bit          halt_en;
	bit          loaded;

	rv_core dut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_halt       (i_halt),
		.o_imem_addr  (o_imem_addr),
		.i_imem_data  (i_imem_data),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.i_dmem_rdata (i_dmem_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==============================
	// Memory models
	// ==============================
	// Fetch past the program end sees NOPs
	assign i_imem_data = (int'(o_imem_addr[31:2]) < prog_len) ?
		prog[o_imem_addr[9:2]] : NOP_INST;
	// Read data only while the core asks for it
	assign i_dmem_rdata = o_dmem_re ? dmem[o_dmem_addr[9:2]] : '0;

	always @(posedge clk)
	begin
		if (o_dmem_we)
		begin
			dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
		end
	end

	// Random halt bursts of 1..4 cycles about one cycle in four
	always @(posedge clk)
	begin
		if (!halt_en || !rst_n)
		begin
			halt_left = 0;
			i_halt <= 1'b0;
		end
		else
		begin
			if (halt_left == 0 && ($urandom % 4) == 0)
			begin
				halt_left = 1 + int'($urandom % 4);
			end
			if (halt_left > 0)
			begin
				halt_left = halt_left - 1;
				i_halt <= 1'b1;
			end
			else
			begin
				i_halt <= 1'b0;
			end
		end
	end

	// ==============================
	// Checks
	// ==============================
	function automatic string test_name(input int t);
		case (t)
			2: return "ALU and forwarding";
			3: return "loads and load-use";
			4: return "control flow";
			default: return "other";
		endcase
	endfunction

	task automatic compare_word(input int t, input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		check_count++;
		if (act !== exp)
		begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
			test_err[t]++;
			err_count++;
		end
	endtask

	task automatic check_reset_outputs(input int t);
		compare_word(t, "o_dmem_we", 32'(0), 32'(o_dmem_we));
		compare_word(t, "o_dmem_re", 32'(0), 32'(o_dmem_re));
		compare_word(t, "o_imem_addr", 32'(0), o_imem_addr);
	endtask

	// One observed store against the next record
	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		int t;
		if (store_idx >= rec_count)
		begin
			t = halt_en ? 5 : 4;
			$display("Unexpected extra store at time %0t to address %h", $time, addr);
			test_err[t]++;
			err_count++;
		end
		else
		begin
			t = halt_en ? 5 : rec_test[store_idx];
			compare_word(t, "o_dmem_addr", rec_addr[store_idx], addr);
			compare_word(t, "o_dmem_wdata", rec_data[store_idx], data);
			// Last record of a test closes it
			if (!halt_en && (store_idx == rec_count - 1 ||
				rec_test[store_idx + 1] != rec_test[store_idx]))
			begin
				$display("Test %0d (%s) done, %0d errors", t, test_name(t), test_err[t]);
			end
			store_idx++;
		end
	endtask

	// Strobe is stable at the falling edge
	always @(negedge clk)
	begin
		if (rst_n && o_dmem_we)
		begin
			check_store(o_dmem_addr, o_dmem_wdata);
		end
	end

	// Reset for 5 cycles with output checks and address-dependent memory fill
	task automatic reset_core(input int t);
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge clk);
			if (i == 0)
			begin
				for (int a = 0; a < 256; a++)
				begin
					dmem[a] = 32'hA5A5_0000 ^ (a * 32'h0001_0101);
				end
			end
			check_reset_outputs(t);
			@(posedge clk);
		end
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_outputs(t);
	endtask

	// Wait for every record then watch for stray stores
	task automatic run_program();
		store_idx = 0;
		while (store_idx < rec_count)
		begin
			@(posedge clk);
		end
		repeat (40) @(posedge clk);
	endtask

	// ==============================
	// Watchdog
	// ==============================
	initial
	begin : watchdog
		int limit;
		wait (loaded);
		limit = 2 * (20 * prog_len + 20 * rec_count + 200);
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles, %0d of %0d stores seen in this run",
			limit, store_idx, rec_count);
		$display("Simulation FAILED");
		$finish;
	end

	// ==============================
	// Main sequence
	// ==============================
	initial
	begin
		rst_n = 1'b0;
		i_halt = 1'b0;
		halt_en = 1'b0;
		loaded = 1'b0;
		halt_left = 0;
		store_idx = 0;
		check_count = 0;
		err_count = 0;
		for (int i = 1; i <= 5; i++)
		begin
			test_err[i] = 0;
		end
		void'($urandom(89));

		$readmemh("tests/rv_core_patterns.mem", pat);
		prog_len = int'(pat[0]);
		for (int i = 0; i < 256; i++)
		begin
			prog[i] = (i < prog_len) ? pat[1 + i] : NOP_INST;
		end
		rec_count = int'(pat[1 + prog_len]);
		for (int r = 0; r < rec_count; r++)
		begin
			rec_test[r] = int'(pat[2 + prog_len + 3 * r]);
			rec_addr[r] = pat[3 + prog_len + 3 * r];
			rec_data[r] = pat[4 + prog_len + 3 * r];
		end
		loaded = 1'b1;

		reset_core(1);
		$display("Test 1 (reset state) done, %0d errors", test_err[1]);
		run_program();

		// Second pass with random freezes
		halt_en <= 1'b1;
		reset_core(5);
		run_program();
		$display("Test 5 (halt) done, %0d errors", test_err[5]);

		$display("Tests run: 5, checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu_exec.sv
hdl/rv_forward_unit.sv
hdl/rv_core.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f all.f --top-module rv_core_tb --Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
	exit 0
fi
exit 1

//--- tests/rv_core_patterns.mem
// Program length, then program words; record count, then records
// Record columns: test number, store address, store data
0000002B
00500093 FFD00113 002081B3 40118233 001242B3 00122333 0062E3B3 0013F433
10802823 10702A23 10302023 10402223 10502423 10602623
05A00493 20902023 20002503 00150593 20B02223 20402603 20C02423
00108463 30102023 00109463 30102023 00114463 30202223 00115463 30202223
0020D463 30102423 0020C463 00C0076F 30102423 30102623 30E02423 0A000793
00478867 30102623 30102823 00000013 31002623 0000006F
0000000D
00000002 00000110 00000001
00000002 00000114 FFFFFFF9
00000002 00000100 00000002
00000002 00000104 FFFFFFFD
00000002 00000108 FFFFFFF8
00000002 0000010C 00000001
00000003 00000200 0000005A
00000003 00000204 0000005B
00000003 00000208 0000005B
00000004 00000300 00000005
00000004 00000304 FFFFFFFD
00000004 00000308 00000084
00000004 0000030C 00000098
